//--- common/dmem_macros.svh
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// word width of the data memory
`define DMEM_DATA_WIDTH 32

// number of words in the data memory
`define DMEM_WORDS 1024

// word address bits, log2 of the depth
`define DMEM_ADDR_WIDTH 10

// one write enable per byte lane
`define DMEM_MASK_WIDTH (`DMEM_DATA_WIDTH / 8)

// core side addresses bytes, two extra bits below the word address
`define DMEM_BYTE_ADDR_WIDTH (`DMEM_ADDR_WIDTH + 2)

`endif

//--- common/dmem_pkg.sv
`include "dmem_macros.svh"

package dmem_pkg;

  // payload and address types
  typedef logic [`DMEM_DATA_WIDTH-1:0] data_t;
  typedef logic [`DMEM_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [`DMEM_BYTE_ADDR_WIDTH-1:0] byte_addr_t;
  typedef logic [`DMEM_MASK_WIDTH-1:0] mask_t;

  // core memory operation
  typedef enum logic [1:0] {
    MEM_LOAD          = 2'b00,
    MEM_STORE         = 2'b01,
    MEM_LOAD_RESERVED = 2'b10
  } mem_op_e;

  // access size, naturally aligned
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

endpackage

//--- dmem_tile.f
+incdir+common
common/dmem_pkg.sv
logic/dmem_sram.sv
logic/dmem_arbiter.sv
logic/reservation_unit.sv
logic/load_packer.sv
logic/dmem_tile_top.sv
testbench/tb_dmem_tile.sv

//--- logic/dmem_arbiter.sv
`timescale 1ns/1ns

`include "dmem_macros.svh"

module dmem_arbiter (
  input core_v_i
  , input core_stall_i
  , input dmem_pkg::mem_op_e core_op_i
  , input dmem_pkg::mem_size_e core_size_i
  , input dmem_pkg::byte_addr_t core_addr_i
  , input dmem_pkg::data_t core_data_i

  , input remote_v_i
  , input remote_w_i
  , input dmem_pkg::word_addr_t remote_addr_i
  , input dmem_pkg::mask_t remote_mask_i
  , input dmem_pkg::data_t remote_data_i
  , output logic remote_yumi_o

  , output logic mem_v_o
  , output logic mem_w_o
  , output dmem_pkg::word_addr_t mem_addr_o
  , output dmem_pkg::mask_t mem_mask_o
  , output dmem_pkg::data_t mem_data_o

  , output logic core_read_accept_o
  , output logic reserve_set_o
);

  import dmem_pkg::*;

  logic core_grant;
  logic core_store;
  logic [1:0] core_offset;
  mask_t store_mask;
  data_t store_data;

  // core wins whenever the pipeline is not stalled
  assign core_grant = core_v_i & ~core_stall_i;
  assign core_store = (core_op_i == MEM_STORE);
  assign core_offset = core_addr_i[1:0];

  // lane enables and replicated store data
  always_comb begin
    case (core_size_i)
      SIZE_BYTE: begin
        store_mask = mask_t'(1) << core_offset;
        store_data = {`DMEM_MASK_WIDTH{core_data_i[7:0]}};
      end
      SIZE_HALF: begin
        store_mask = mask_t'(3) << {core_offset[1], 1'b0};
        store_data = {(`DMEM_MASK_WIDTH/2){core_data_i[15:0]}};
      end
      default: begin
        store_mask = '1;
        store_data = core_data_i;
      end
    endcase
  end

  // port mux
  always_comb begin
    if (core_grant) begin
      mem_v_o = 1'b1;
      mem_w_o = core_store;
      mem_addr_o = core_addr_i[`DMEM_BYTE_ADDR_WIDTH-1:2];
      mem_mask_o = store_mask;
      mem_data_o = store_data;
    end
    else begin
      mem_v_o = remote_v_i;
      mem_w_o = remote_w_i;
      mem_addr_o = remote_addr_i;
      mem_mask_o = remote_mask_i;
      mem_data_o = remote_data_i;
    end
  end

  assign remote_yumi_o = remote_v_i & ~core_grant;
  assign core_read_accept_o = core_grant & ~core_store;
  assign reserve_set_o = core_grant & (core_op_i == MEM_LOAD_RESERVED);

endmodule

//--- logic/dmem_sram.sv
`timescale 1ns/1ns

`include "dmem_macros.svh"

module dmem_sram (
  input clk_i

  , input v_i
  , input w_i
  , input dmem_pkg::word_addr_t addr_i
  , input dmem_pkg::mask_t mask_i
  , input dmem_pkg::data_t data_i

  , output dmem_pkg::data_t data_o
);

  import dmem_pkg::*;

  data_t mem_r [`DMEM_WORDS];
  data_t data_r;

  // single port, a write and a read never happen in the same cycle
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        for (int i = 0; i < `DMEM_MASK_WIDTH; i++) begin
          if (mask_i[i]) begin
            mem_r[addr_i][8*i +: 8] <= data_i[8*i +: 8];
          end
        end
      end
      else begin
        // read word stays put until the next read
        data_r <= mem_r[addr_i];
      end
    end
  end

  assign data_o = data_r;

  // neither the core store path nor the remote side may send a write with no lanes
  assert property (@(posedge clk_i) (v_i && w_i) |-> (mask_i != '0))
    else $error("dmem write with empty byte mask");

endmodule

//--- logic/dmem_tile_top.sv
`timescale 1ns/1ns

module dmem_tile_top (
  input clk_i
  , input reset_i

  // core request
  , input core_v_i
  , input dmem_pkg::mem_op_e core_op_i
  , input dmem_pkg::mem_size_e core_size_i
  , input core_unsigned_i
  , input dmem_pkg::byte_addr_t core_addr_i
  , input dmem_pkg::data_t core_data_i
  , input core_stall_i

  // remote request
  , input remote_v_i
  , input remote_w_i
  , input dmem_pkg::word_addr_t remote_addr_i
  , input dmem_pkg::mask_t remote_mask_i
  , input dmem_pkg::data_t remote_data_i
  , output logic remote_yumi_o
  , output dmem_pkg::data_t remote_data_o

  // core results
  , output logic core_load_v_o
  , output dmem_pkg::data_t core_load_data_o
  , output logic reservation_o
);

  import dmem_pkg::*;

  logic mem_v;
  logic mem_w;
  word_addr_t mem_addr;
  mask_t mem_mask;
  data_t mem_data;
  data_t mem_rdata;
  logic core_read_accept;
  logic reserve_set;

  dmem_arbiter arb (
    .core_v_i(core_v_i)
    ,.core_stall_i(core_stall_i)
    ,.core_op_i(core_op_i)
    ,.core_size_i(core_size_i)
    ,.core_addr_i(core_addr_i)
    ,.core_data_i(core_data_i)
    ,.remote_v_i(remote_v_i)
    ,.remote_w_i(remote_w_i)
    ,.remote_addr_i(remote_addr_i)
    ,.remote_mask_i(remote_mask_i)
    ,.remote_data_i(remote_data_i)
    ,.remote_yumi_o(remote_yumi_o)
    ,.mem_v_o(mem_v)
    ,.mem_w_o(mem_w)
    ,.mem_addr_o(mem_addr)
    ,.mem_mask_o(mem_mask)
    ,.mem_data_o(mem_data)
    ,.core_read_accept_o(core_read_accept)
    ,.reserve_set_o(reserve_set)
  );

  dmem_sram dmem (
    .clk_i(clk_i)
    ,.v_i(mem_v)
    ,.w_i(mem_w)
    ,.addr_i(mem_addr)
    ,.mask_i(mem_mask)
    ,.data_i(mem_data)
    ,.data_o(mem_rdata)
  );

  // watches the same port controls the memory sees
  reservation_unit resv (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.reserve_set_i(reserve_set)
    ,.mem_v_i(mem_v)
    ,.mem_w_i(mem_w)
    ,.mem_addr_i(mem_addr)
    ,.reservation_o(reservation_o)
  );

  load_packer lp (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.read_accept_i(core_read_accept)
    ,.size_i(core_size_i)
    ,.unsigned_i(core_unsigned_i)
    ,.offset_i(core_addr_i[1:0])
    ,.mem_data_i(mem_rdata)
    ,.load_v_o(core_load_v_o)
    ,.load_data_o(core_load_data_o)
  );

  // remote side reads straight from the held read word
  assign remote_data_o = mem_rdata;

endmodule

//--- logic/load_packer.sv
`timescale 1ns/1ns

`include "dmem_macros.svh"

module load_packer (
  input clk_i
  , input reset_i

  , input read_accept_i
  , input dmem_pkg::mem_size_e size_i
  , input unsigned_i
  , input [1:0] offset_i
  , input dmem_pkg::data_t mem_data_i

  , output logic load_v_o
  , output dmem_pkg::data_t load_data_o
);

  import dmem_pkg::*;

  logic load_v_r;
  mem_size_e size_r;
  logic unsigned_r;
  logic [1:0] offset_r;

  logic [7:0] load_byte;
  logic [15:0] load_half;
  logic sign_bit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_v_r <= 1'b0;
    end
    else begin
      load_v_r <= read_accept_i;
    end
  end

  // access info lines up with the memory word one cycle later
  always_ff @(posedge clk_i) begin
    if (read_accept_i) begin
      size_r <= size_i;
      unsigned_r <= unsigned_i;
      offset_r <= offset_i;
    end
  end

  assign load_byte = mem_data_i[{offset_r, 3'b000} +: 8];
  assign load_half = mem_data_i[{offset_r[1], 4'b0000} +: 16];

  always_comb begin
    case (size_r)
      SIZE_BYTE: begin
        sign_bit = ~unsigned_r & load_byte[7];
        load_data_o = {{(`DMEM_DATA_WIDTH-8){sign_bit}}, load_byte};
      end
      SIZE_HALF: begin
        sign_bit = ~unsigned_r & load_half[15];
        load_data_o = {{(`DMEM_DATA_WIDTH-16){sign_bit}}, load_half};
      end
      default: begin
        sign_bit = 1'b0;
        load_data_o = mem_data_i;
      end
    endcase
  end

  assign load_v_o = load_v_r;

endmodule

//--- logic/reservation_unit.sv
`timescale 1ns/1ns

module reservation_unit (
  input clk_i
  , input reset_i

  , input reserve_set_i
  , input mem_v_i
  , input mem_w_i
  , input dmem_pkg::word_addr_t mem_addr_i

  , output logic reservation_o
);

  import dmem_pkg::*;

  logic reserved_r;
  word_addr_t reserved_addr_r;
  logic break_hit;

  // any accepted write to the reserved word, core or remote
  assign break_hit = reserved_r & mem_v_i & mem_w_i & (mem_addr_i == reserved_addr_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reserved_r <= 1'b0;
    end
    else if (reserve_set_i) begin
      reserved_r <= 1'b1;
    end
    else if (break_hit) begin
      reserved_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reserve_set_i) begin
      reserved_addr_r <= mem_addr_i;
    end
  end

  assign reservation_o = reserved_r;

  // set comes from a core read grant, so the port cannot carry a write then
  assert property (@(posedge clk_i) disable iff (reset_i)
    reserve_set_i |-> !(mem_v_i && mem_w_i))
    else $error("reservation set together with a memory write");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f dmem_tile.f \
  --top-module tb_dmem_tile -o sim_dmem_tile &&
  ./obj_dir/sim_dmem_tile | tee /dev/stderr | grep -q "^=== PASS ===$" &&
  echo "simulation passed" || {
    echo "simulation failed"
    exit 1
  }

//--- testbench/tb_dmem_tile.sv
`timescale 1ns/1ns

module tb_dmem_tile;

  import dmem_pkg::*;

  localparam int N_WORDS = 16;
  localparam int N_CORE = 200;
  localparam int N_REMOTE = 40;
  localparam int N_ARB = 8;
  localparam int N_RESV = 4;
  localparam int N_MIX = 300;
  // remote round is four accesses, arbitration round three, reservation round about six
  localparam int TOTAL_TXN = N_WORDS + N_CORE + 4*N_REMOTE + 3*N_ARB + 6*N_RESV + N_MIX;
  localparam int CYCLE_LIMIT = 4*TOTAL_TXN + 200;

  logic clk_i = 1'b0;
  logic reset_i;
  logic core_v_i;
  mem_op_e core_op_i;
  mem_size_e core_size_i;
  logic core_unsigned_i;
  byte_addr_t core_addr_i;
  data_t core_data_i;
  logic core_stall_i;
  logic remote_v_i;
  logic remote_w_i;
  word_addr_t remote_addr_i;
  mask_t remote_mask_i;
  data_t remote_data_i;
  logic remote_yumi_o;
  data_t remote_data_o;
  logic core_load_v_o;
  data_t core_load_data_o;
  logic reservation_o;

  // reference model state
  data_t mem_m [N_WORDS];
  logic resv_m = 1'b0;
  word_addr_t resv_addr_m = '0;
  logic load_pend = 1'b0;
  data_t load_exp;
  logic rd_known = 1'b0;
  data_t rd_exp;
  logic yumi_seen;

  string test_name;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  dmem_tile_top DUT (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_data(input string what, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s finished, no errors", test_name);
    end
    else begin
      tests_failed++;
      $display("test %s finished, %0d errors", test_name, errors - test_errors);
    end
  endtask

  function automatic word_addr_t rand_word();
    return word_addr_t'($urandom_range(N_WORDS - 1, 0));
  endfunction

  // naturally aligned byte address inside the test window
  function automatic byte_addr_t rand_core_addr(input mem_size_e sz);
    logic [1:0] off;
    off = 2'($urandom_range(3, 0));
    if (sz == SIZE_HALF) begin
      off[0] = 1'b0;
    end
    else if (sz == SIZE_WORD) begin
      off = 2'b00;
    end
    return {rand_word(), off};
  endfunction

  function automatic data_t expected_load(input data_t word, input mem_size_e sz,
                                          input logic uns, input logic [1:0] off);
    logic [7:0] b;
    logic [15:0] h;
    b = word[{off, 3'b000} +: 8];
    h = word[{off[1], 4'b0000} +: 16];
    case (sz)
      SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default: return word;
    endcase
  endfunction

  task automatic drive_core(input logic v, input mem_op_e op, input mem_size_e sz,
                            input logic uns, input byte_addr_t a, input data_t d);
    core_v_i = v;
    core_op_i = op;
    core_size_i = sz;
    core_unsigned_i = uns;
    core_addr_i = a;
    core_data_i = d;
  endtask

  task automatic drive_remote(input logic v, input logic w, input word_addr_t a,
                              input mask_t m, input data_t d);
    remote_v_i = v;
    remote_w_i = w;
    remote_addr_i = a;
    remote_mask_i = m;
    remote_data_i = d;
  endtask

  // called at a falling edge with inputs driven, returns at the next falling edge
  task automatic run_cycle();
    logic core_acc;
    logic yumi_exp;
    word_addr_t ca;
    data_t lanes;
    #5;
    core_acc = core_v_i & ~core_stall_i;
    yumi_exp = remote_v_i & ~core_acc;
    check_flag("remote yumi", yumi_exp, remote_yumi_o);
    yumi_seen = remote_yumi_o;
    ca = word_addr_t'(core_addr_i >> 2);
    load_pend = 1'b0;
    if (core_acc && core_op_i == MEM_STORE) begin
      case (core_size_i)
        SIZE_BYTE: mem_m[ca[3:0]][{core_addr_i[1:0], 3'b000} +: 8] = core_data_i[7:0];
        SIZE_HALF: mem_m[ca[3:0]][{core_addr_i[1], 4'b0000} +: 16] = core_data_i[15:0];
        default: mem_m[ca[3:0]] = core_data_i;
      endcase
      if (ca == resv_addr_m) begin
        resv_m = 1'b0;
      end
    end
    else if (core_acc) begin
      load_pend = 1'b1;
      load_exp = expected_load(mem_m[ca[3:0]], core_size_i, core_unsigned_i,
                               core_addr_i[1:0]);
      rd_exp = mem_m[ca[3:0]];
      rd_known = 1'b1;
      if (core_op_i == MEM_LOAD_RESERVED) begin
        resv_m = 1'b1;
        resv_addr_m = ca;
      end
    end
    else if (yumi_exp && remote_w_i) begin
      lanes = {{8{remote_mask_i[3]}}, {8{remote_mask_i[2]}},
               {8{remote_mask_i[1]}}, {8{remote_mask_i[0]}}};
      mem_m[remote_addr_i[3:0]] = (mem_m[remote_addr_i[3:0]] & ~lanes) |
                                  (remote_data_i & lanes);
      if (remote_addr_i == resv_addr_m) begin
        resv_m = 1'b0;
      end
    end
    else if (yumi_exp) begin
      rd_exp = mem_m[remote_addr_i[3:0]];
      rd_known = 1'b1;
    end
    @(negedge clk_i);
    check_flag("load valid", load_pend, core_load_v_o);
    if (load_pend) begin
      check_data("load data", load_exp, core_load_data_o);
    end
    check_flag("reservation", resv_m, reservation_o);
    if (rd_known) begin
      check_data("read word", rd_exp, remote_data_o);
    end
  endtask

  // remote side holds its request until it sees yumi
  task automatic wait_yumi();
    do begin
      run_cycle();
    end while (!yumi_seen);
    remote_v_i = 1'b0;
  endtask

  initial begin : main
    mem_size_e sz;
    word_addr_t wa;
    word_addr_t other;
    void'($urandom(32'hee73));
    reset_i = 1'b1;
    core_stall_i = 1'b0;
    drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
    drive_remote(1'b0, 1'b0, '0, '0, '0);
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;

    begin_test("reset");
    check_flag("load valid", 1'b0, core_load_v_o);
    check_flag("reservation", 1'b0, reservation_o);
    check_flag("remote yumi", 1'b0, remote_yumi_o);
    end_test();

    begin_test("preload");
    for (int i = 0; i < N_WORDS; i++) begin
      drive_remote(1'b1, 1'b1, word_addr_t'(i), 4'hf, $urandom);
      wait_yumi();
    end
    end_test();

    begin_test("core_load_store");
    for (int i = 0; i < N_CORE; i++) begin
      sz = mem_size_e'($urandom_range(2, 0));
      drive_core(1'b1, ($urandom_range(1, 0) == 1) ? MEM_STORE : MEM_LOAD, sz,
                 $urandom_range(1, 0) == 1, rand_core_addr(sz), $urandom);
      run_cycle();
    end
    drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
    run_cycle();
    end_test();

    begin_test("remote_rw");
    for (int i = 0; i < N_REMOTE; i++) begin
      wa = rand_word();
      drive_remote(1'b1, 1'b1, wa, mask_t'($urandom_range(15, 1)), $urandom);
      wait_yumi();
      drive_remote(1'b1, 1'b0, wa, '0, '0);
      wait_yumi();
      // read word must hold while core stores run
      repeat (2) begin
        drive_core(1'b1, MEM_STORE, SIZE_WORD, 1'b0, {rand_word(), 2'b00}, $urandom);
        run_cycle();
      end
      drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
    end
    end_test();

    begin_test("arbitration");
    for (int i = 0; i < N_ARB; i++) begin
      wa = rand_word();
      // core word and remote low half land in the same word, read back below
      drive_core(1'b1, MEM_STORE, SIZE_WORD, 1'b0, {wa, 2'b00}, $urandom);
      drive_remote(1'b1, 1'b1, wa, 4'b0011, $urandom);
      run_cycle();
      check_flag("yumi with core granted", 1'b0, yumi_seen);
      core_stall_i = 1'b1;
      core_op_i = MEM_LOAD;
      run_cycle();
      check_flag("yumi under stall", 1'b1, yumi_seen);
      remote_v_i = 1'b0;
      core_stall_i = 1'b0;
      drive_core(1'b1, MEM_LOAD, SIZE_WORD, 1'b0, {wa, 2'b00}, '0);
      run_cycle();
      drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
    end
    run_cycle();
    end_test();

    begin_test("reservation");
    for (int r = 0; r < N_RESV; r++) begin
      wa = rand_word();
      other = wa ^ word_addr_t'($urandom_range(N_WORDS - 1, 1));
      drive_core(1'b1, MEM_LOAD_RESERVED, SIZE_WORD, 1'b0, {wa, 2'b00}, '0);
      run_cycle();
      drive_core(1'b1, MEM_STORE, SIZE_BYTE, 1'b0, {other, 2'b11}, $urandom);
      run_cycle();
      drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
      drive_remote(1'b1, 1'b1, other, 4'hf, $urandom);
      wait_yumi();
      check_flag("held after other writes", 1'b1, reservation_o);
      // break alternately from the remote side and from the core
      if (r[0]) begin
        drive_remote(1'b1, 1'b1, wa, 4'b0100, $urandom);
        wait_yumi();
      end
      else begin
        drive_core(1'b1, MEM_STORE, SIZE_HALF, 1'b0, {wa, 2'b10}, $urandom);
        run_cycle();
        drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
      end
      check_flag("dropped after reserved write", 1'b0, reservation_o);
    end
    end_test();

    begin_test("mixed_stream");
    for (int i = 0; i < N_MIX; i++) begin
      sz = mem_size_e'($urandom_range(2, 0));
      drive_core($urandom_range(9, 0) < 6, mem_op_e'($urandom_range(2, 0)), sz,
                 $urandom_range(1, 0) == 1, rand_core_addr(sz), $urandom);
      core_stall_i = $urandom_range(3, 0) == 0;
      if (!remote_v_i && $urandom_range(1, 0) == 1) begin
        drive_remote(1'b1, $urandom_range(1, 0) == 1, rand_word(),
                     mask_t'($urandom_range(15, 1)), $urandom);
      end
      run_cycle();
      if (yumi_seen) begin
        remote_v_i = 1'b0;
      end
    end
    drive_core(1'b0, MEM_LOAD, SIZE_WORD, 1'b0, '0, '0);
    core_stall_i = 1'b0;
    if (remote_v_i) begin
      wait_yumi();
    end
    run_cycle();
    end_test();

    $display("tests %0d run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end
    else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
